/* tb.f */
+incdir+src
+incdir+bench
src/mips_pkg.sv
src/maindec.sv
src/operand_fetch.sv
src/id_ex_reg.sv
src/decode_stage.sv
bench/tb_decode_stage.sv

/* bench/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

`include "mips.svh"

// one expected decode result.
typedef struct packed {
    decoded_op_t op;
    logic        ri;
    control_t    ctl;
    word_t       srca;
    word_t       srcb;
    word_t       store;
    reg_addr_t   dst;
    logic [4:0]  shamt;
} result_t;

word_t shadow [0:31];

function automatic word_t shadow_read(input reg_addr_t a, input logic we,
                                      input reg_addr_t wa, input word_t wd);
    if (a == 5'd0) return '0;
    if (we && (wa == a)) return wd;  // same-cycle write.
    return shadow[a];
endfunction

task automatic shadow_write(input reg_addr_t a, input word_t d);
    if (a != 5'd0) shadow[a] = d;
endtask

function automatic decoded_op_t model_op(input word_t w);
    case (w[31:26])
        `OP_RT: begin
            case (w[5:0])
                `F_ADD: return ADD;
                `F_ADDU: return ADDU;
                `F_SUB: return SUB;
                `F_SUBU: return SUBU;
                `F_SLT: return SLT;
                `F_SLTU: return SLTU;
                `F_AND: return AND;
                `F_OR: return OR;
                `F_XOR: return XOR;
                `F_NOR: return NOR;
                `F_SLL: return SLL;
                `F_SRL: return SRL;
                `F_SRA: return SRA;
                `F_SLLV: return SLLV;
                `F_SRLV: return SRLV;
                `F_SRAV: return SRAV;
                `F_JR: return JR;
                `F_JALR: return JALR;
                `F_MULT: return MULT;
                `F_MULTU: return MULTU;
                `F_DIV: return DIV;
                `F_DIVU: return DIVU;
                `F_MFHI: return MFHI;
                `F_MFLO: return MFLO;
                `F_MTHI: return MTHI;
                `F_MTLO: return MTLO;
                `F_BREAK: return BREAK;
                `F_SYSCALL: return SYSCALL;
                default: return RESERVED;
            endcase
        end
        `OP_BGEZ: begin
            case (w[20:16])
                `B_BGEZ: return BGEZ;
                `B_BLTZ: return BLTZ;
                `B_BGEZAL: return BGEZAL;
                `B_BLTZAL: return BLTZAL;
                default: return RESERVED;
            endcase
        end
        `OP_ERET: begin
            case (w[25:21])
                `C_ERET: return ERET;
                `C_MFC0: return MFC0;
                `C_MTC0: return MTC0;
                default: return RESERVED;
            endcase
        end
        `OP_ADDI: return ADD;
        `OP_ADDIU: return ADDU;
        `OP_SLTI: return SLT;
        `OP_SLTIU: return SLTU;
        `OP_ANDI: return AND;
        `OP_ORI: return OR;
        `OP_XORI: return XOR;
        `OP_LUI: return LUI;
        `OP_BEQ: return BEQ;
        `OP_BNE: return BNE;
        `OP_BGTZ: return BGTZ;
        `OP_BLEZ: return BLEZ;
        `OP_J: return J;
        `OP_JAL: return JAL;
        `OP_LB: return LB;
        `OP_LBU: return LBU;
        `OP_LH: return LH;
        `OP_LHU: return LHU;
        `OP_LW: return LW;
        `OP_SB: return SB;
        `OP_SH: return SH;
        `OP_SW: return SW;
        default: return RESERVED;
    endcase
endfunction

function automatic control_t model_ctl(input word_t w, input decoded_op_t op);
    control_t c;
    logic     alu_op;
    logic     imm_form;
    c = '0;
    alu_op = 1'b0;
    imm_form = (w[31:26] != `OP_RT);
    case (op)
        ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR, LUI,
        SLL, SRL, SRA, SLLV, SRLV, SRAV: alu_op = 1'b1;
        default: ;
    endcase
    case (op)
        LB, LBU, LH, LHU, LW: c.memread = 1'b1;
        SB, SH, SW: c.memwrite = 1'b1;
        JAL, JALR, BGEZAL, BLTZAL, MFHI, MFLO, MFC0: c.regwrite = 1'b1;
        default: c.regwrite = alu_op;
    endcase
    c.regwrite = c.regwrite | c.memread;
    if (c.memread || c.memwrite || (alu_op && imm_form)) c.alusrc = IMM;
    if (c.memread || (op == MFC0) || (alu_op && imm_form)) c.regdst = RT;
    c.zeroext = imm_form && ((op == AND) || (op == OR) || (op == XOR));
    c.shamt_valid = (op == SLL) || (op == SRL) || (op == SRA);
    case (op)
        ADDU: c.alufunc = ALU_ADDU;
        SUB: c.alufunc = ALU_SUB;
        SUBU: c.alufunc = ALU_SUBU;
        SLT: c.alufunc = ALU_SLT;
        SLTU: c.alufunc = ALU_SLTU;
        AND: c.alufunc = ALU_AND;
        OR: c.alufunc = ALU_OR;
        XOR: c.alufunc = ALU_XOR;
        NOR: c.alufunc = ALU_NOR;
        LUI: c.alufunc = ALU_LUI;
        SLL, SLLV: c.alufunc = ALU_SLL;
        SRL, SRLV: c.alufunc = ALU_SRL;
        SRA, SRAV: c.alufunc = ALU_SRA;
        JR, JALR, MFHI, MFLO, MTHI, MTLO, BREAK, SYSCALL, RESERVED: c.alufunc = ALU_PASSA;
        default: c.alufunc = ALU_ADD;
    endcase
    return c;
endfunction

function automatic result_t model_result(input word_t w, input word_t rs_v, input word_t rt_v);
    result_t r;
    word_t   imm;
    r.op = model_op(w);
    r.ri = (r.op == RESERVED);
    r.ctl = model_ctl(w, r.op);
    if (r.op == LUI) imm = {w[15:0], 16'h0000};
    else if (r.ctl.zeroext) imm = {16'h0000, w[15:0]};
    else imm = {{16{w[15]}}, w[15:0]};
    r.srca = rs_v;
    r.srcb = (r.ctl.alusrc == IMM) ? imm : rt_v;
    r.store = rt_v;
    if (!r.ctl.regwrite) r.dst = 5'd0;
    else if ((r.op == JAL) || (r.op == BGEZAL) || (r.op == BLTZAL)) r.dst = 5'd31;
    else r.dst = (r.ctl.regdst == RT) ? w[20:16] : w[15:11];
    r.shamt = r.ctl.shamt_valid ? w[10:6] : 5'd0;
    return r;
endfunction

`endif

/* bench/tb_decode_stage.sv */
`default_nettype none

module tb_decode_stage import mips_pkg::*; ();

    localparam int PERIOD  = 4;
    localparam int N_TXN   = 2000;
    localparam int TIMEOUT = 4 * N_TXN * PERIOD;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    word_t       in_instr;
    logic        wb_en;
    reg_addr_t   wb_addr;
    word_t       wb_data;
    logic        out_valid;
    logic        out_ready;
    decoded_op_t out_op;
    control_t    out_ctl;
    logic        out_exception_ri;
    word_t       out_srca;
    word_t       out_srcb;
    word_t       out_store_data;
    reg_addr_t   out_dst;
    logic [4:0]  out_shamt;

    `include "decode_model.svh"

    integer  seed;
    int      taken;
    logic    held;
    logic    accepted_last;
    result_t exp_q [$];
    result_t e;
    result_t snap;
    op_t     prim_ops [0:21];
    func_t   funcs [0:27];
    logic [4:0] regimm_rt [0:3];
    logic [4:0] cop0_rs [0:2];

    decode_stage i_decode_stage (.*);

    always #(PERIOD / 2) clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_op(input string name, input decoded_op_t got, input decoded_op_t exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t: %s got %s expected %s",
                                   $time, name, got.name(), exp.name()));
    endtask

    task automatic check_alu(input string name, input alufunc_t got, input alufunc_t exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t: %s got %s expected %s",
                                   $time, name, got.name(), exp.name()));
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t: %s got %h expected %h",
                                   $time, name, got, exp));
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                   $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t: %s got %b expected %b",
                                   $time, name, got, exp));
    endtask

    task automatic compare_result(input result_t r);
        check_op("out_op", out_op, r.op);
        check_bit("out_exception_ri", out_exception_ri, r.ri);
        check_bit("out_ctl.regwrite", out_ctl.regwrite, r.ctl.regwrite);
        check_bit("out_ctl.memread", out_ctl.memread, r.ctl.memread);
        check_bit("out_ctl.memwrite", out_ctl.memwrite, r.ctl.memwrite);
        check_bit("out_ctl.alusrc", out_ctl.alusrc, r.ctl.alusrc);
        check_bit("out_ctl.regdst", out_ctl.regdst, r.ctl.regdst);
        check_alu("out_ctl.alufunc", out_ctl.alufunc, r.ctl.alufunc);
        check_word("out_srca", out_srca, r.srca);
        check_word("out_srcb", out_srcb, r.srcb);
        check_word("out_store_data", out_store_data, r.store);
        check_reg("out_dst", out_dst, r.dst);
        check_reg("out_shamt", out_shamt, r.shamt);
    endtask

    // about one in ten words is a reserved encoding.
    function automatic word_t gen_instr();
        word_t w;
        int    k;
        w = $random(seed);
        k = {$random(seed)} % 10;
        if (k == 0) begin
            case ({$random(seed)} % 3)
                0: w[31:30] = 2'b11;  // unused opcode range.
                1: begin
                    w[31:26] = `OP_RT;
                    w[5:0] = 6'b111111;
                end
                default: begin
                    w[31:26] = `OP_BGEZ;
                    w[20:16] = 5'b11111;
                end
            endcase
        end else if (k <= 3) begin
            w[31:26] = `OP_RT;
            w[5:0] = funcs[{$random(seed)} % 28];
        end else if (k == 4) begin
            if ({$random(seed)} % 2) begin
                w[31:26] = `OP_BGEZ;
                w[20:16] = regimm_rt[{$random(seed)} % 4];
            end else begin
                w[31:26] = `OP_ERET;
                w[25:21] = cop0_rs[{$random(seed)} % 3];
            end
        end else begin
            w[31:26] = prim_ops[{$random(seed)} % 22];
        end
        return w;
    endfunction

    initial begin
        seed = 42165;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        out_ready = 1'b0;
        taken = 0;
        held = 1'b0;
        accepted_last = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        prim_ops = '{`OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_ADDI,
                     `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
                     `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW};
        funcs = '{`F_SLL, `F_SRL, `F_SRA, `F_SLLV, `F_SRLV, `F_SRAV, `F_JR, `F_JALR,
                  `F_SYSCALL, `F_BREAK, `F_MFHI, `F_MTHI, `F_MFLO, `F_MTLO, `F_MULT,
                  `F_MULTU, `F_DIV, `F_DIVU, `F_ADD, `F_ADDU, `F_SUB, `F_SUBU, `F_AND,
                  `F_OR, `F_XOR, `F_NOR, `F_SLT, `F_SLTU};
        regimm_rt = '{`B_BLTZ, `B_BGEZ, `B_BLTZAL, `B_BGEZAL};
        cop0_rs = '{`C_MFC0, `C_MTC0, `C_ERET};
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("in_ready", in_ready, 1'b1);
        forever begin
            if (!in_valid || in_ready) begin  // hold an offer until it is taken.
                in_valid <= ({$random(seed)} % 4) != 0;
                in_instr <= gen_instr();
            end
            out_ready <= ({$random(seed)} % 4) != 0;
            wb_en <= {$random(seed)} % 2;
            wb_addr <= $random(seed);
            wb_data <= $random(seed);
            @(posedge clk);
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (accepted_last) check_bit("out_valid", out_valid, 1'b1);
            if (held) begin
                check_bit("out_valid", out_valid, 1'b1);
                compare_result(snap);  // outputs must not move while waiting.
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    report_error("DUT produced a result that was never accepted");
                end else begin
                    e = exp_q.pop_front();
                    compare_result(e);
                    taken++;
                end
            end
            accepted_last = in_valid && in_ready;
            if (accepted_last)
                exp_q.push_back(model_result(in_instr,
                    shadow_read(in_instr[25:21], wb_en, wb_addr, wb_data),
                    shadow_read(in_instr[20:16], wb_en, wb_addr, wb_data)));
            if (wb_en) shadow_write(wb_addr, wb_data);
            held = out_valid && !out_ready;
            snap.op = out_op;
            snap.ri = out_exception_ri;
            snap.ctl = out_ctl;
            snap.srca = out_srca;
            snap.srcb = out_srcb;
            snap.store = out_store_data;
            snap.dst = out_dst;
            snap.shamt = out_shamt;
            if (taken == N_TXN) begin
                $display("TEST OK");
                $finish;
            end
        end
    end

    initial begin
        #(TIMEOUT);
        report_error($sformatf("run timed out with %0d of %0d results taken", taken, N_TXN));
    end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`default_nettype none

module decode_stage import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  word_t       in_instr,
    input  logic        wb_en,
    input  reg_addr_t   wb_addr,
    input  word_t       wb_data,
    output logic        out_valid,
    input  logic        out_ready,
    output decoded_op_t out_op,
    output control_t    out_ctl,
    output logic        out_exception_ri,
    output word_t       out_srca,
    output word_t       out_srcb,
    output word_t       out_store_data,
    output reg_addr_t   out_dst,
    output logic [4:0]  out_shamt
);

    decoded_op_t op;
    control_t    ctl;
    logic        exception_ri;
    word_t       rs_data;
    word_t       rt_data;

    maindec i_maindec (
        .instr        (in_instr),
        .op           (op),
        .exception_ri (exception_ri),
        .ctl          (ctl)
    );

    operand_fetch i_operand_fetch (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (in_instr[25:21]),
        .rt_addr (in_instr[20:16]),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    id_ex_reg i_id_ex_reg (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .out_ready        (out_ready),
        .instr            (in_instr),
        .op               (op),
        .ctl              (ctl),
        .exception_ri     (exception_ri),
        .rs_data          (rs_data),
        .rt_data          (rt_data),
        .out_valid        (out_valid),
        .out_op           (out_op),
        .out_ctl          (out_ctl),
        .out_exception_ri (out_exception_ri),
        .out_srca         (out_srca),
        .out_srcb         (out_srcb),
        .out_store_data   (out_store_data),
        .out_dst          (out_dst),
        .out_shamt        (out_shamt)
    );

endmodule

`default_nettype wire

/* src/id_ex_reg.sv */
`default_nettype none

module id_ex_reg import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic        out_ready,
    input  word_t       instr,
    input  decoded_op_t op,
    input  control_t    ctl,
    input  logic        exception_ri,
    input  word_t       rs_data,
    input  word_t       rt_data,
    output logic        out_valid,
    output decoded_op_t out_op,
    output control_t    out_ctl,
    output logic        out_exception_ri,
    output word_t       out_srca,
    output word_t       out_srcb,
    output word_t       out_store_data,
    output reg_addr_t   out_dst,
    output logic [4:0]  out_shamt
);

    word_t     imm;
    reg_addr_t dst;
    logic      accept;

    assign in_ready = !out_valid || out_ready;  // empty or draining.
    assign accept   = in_valid && in_ready;

    always_comb begin
        if (op == LUI) begin
            imm = {instr[15:0], 16'h0000};
        end else if (ctl.zeroext) begin
            imm = {16'h0000, instr[15:0]};
        end else begin
            imm = {{16{instr[15]}}, instr[15:0]};
        end
    end

    always_comb begin
        if (!ctl.regwrite) begin
            dst = '0;
        end else if ((op == JAL) || (op == BGEZAL) || (op == BLTZAL)) begin
            dst = 5'd31;  // link register.
        end else if (ctl.regdst == RT) begin
            dst = instr[20:16];
        end else begin
            dst = instr[15:11];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // payload only moves on acceptance.
    always_ff @(posedge clk) begin
        if (accept) begin
            out_op           <= op;
            out_ctl          <= ctl;
            out_exception_ri <= exception_ri;
            out_srca         <= rs_data;
            out_srcb         <= (ctl.alusrc == IMM) ? imm : rt_data;
            out_store_data   <= rt_data;
            out_dst          <= dst;
            out_shamt        <= ctl.shamt_valid ? instr[10:6] : 5'd0;
        end
    end

endmodule

`default_nettype wire

/* src/operand_fetch.sv */
`default_nettype none

module operand_fetch import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [0:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // $0 reads zero, otherwise a same-cycle write wins.
    assign rs_data = (rs_addr == '0) ? '0 :
                     (wb_en && (wb_addr == rs_addr)) ? wb_data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (wb_en && (wb_addr == rt_addr)) ? wb_data : regs[rt_addr];

endmodule

`default_nettype wire

/* src/maindec.sv */
`default_nettype none
`include "mips.svh"

module maindec import mips_pkg::*; (
    input  word_t       instr,
    output decoded_op_t op,
    output logic        exception_ri,
    output control_t    ctl
);

    op_t   opcode;
    func_t func;
    logic  imm_form;

    assign opcode   = instr[31:26];
    assign func     = instr[5:0];
    assign imm_form = (opcode != `OP_RT);

    // classify the word.
    always_comb begin
        op = RESERVED;
        case (opcode)
            `OP_ADDI:  op = ADD;
            `OP_ADDIU: op = ADDU;
            `OP_SLTI:  op = SLT;
            `OP_SLTIU: op = SLTU;
            `OP_ANDI:  op = AND;
            `OP_ORI:   op = OR;
            `OP_XORI:  op = XOR;
            `OP_LUI:   op = LUI;
            `OP_BEQ:   op = BEQ;
            `OP_BNE:   op = BNE;
            `OP_BGTZ:  op = BGTZ;
            `OP_BLEZ:  op = BLEZ;
            `OP_J:     op = J;
            `OP_JAL:   op = JAL;
            `OP_LB:    op = LB;
            `OP_LBU:   op = LBU;
            `OP_LH:    op = LH;
            `OP_LHU:   op = LHU;
            `OP_LW:    op = LW;
            `OP_SB:    op = SB;
            `OP_SH:    op = SH;
            `OP_SW:    op = SW;
            `OP_BGEZ: begin
                case (instr[20:16])
                    `B_BGEZ:   op = BGEZ;
                    `B_BLTZ:   op = BLTZ;
                    `B_BGEZAL: op = BGEZAL;
                    `B_BLTZAL: op = BLTZAL;
                    default:   op = RESERVED;
                endcase
            end
            `OP_ERET: begin
                case (instr[25:21])
                    `C_ERET: op = ERET;
                    `C_MFC0: op = MFC0;
                    `C_MTC0: op = MTC0;
                    default: op = RESERVED;
                endcase
            end
            `OP_RT: begin
                case (func)
                    `F_ADD:     op = ADD;
                    `F_ADDU:    op = ADDU;
                    `F_SUB:     op = SUB;
                    `F_SUBU:    op = SUBU;
                    `F_SLT:     op = SLT;
                    `F_SLTU:    op = SLTU;
                    `F_AND:     op = AND;
                    `F_OR:      op = OR;
                    `F_XOR:     op = XOR;
                    `F_NOR:     op = NOR;
                    `F_SLL:     op = SLL;
                    `F_SRL:     op = SRL;
                    `F_SRA:     op = SRA;
                    `F_SLLV:    op = SLLV;
                    `F_SRLV:    op = SRLV;
                    `F_SRAV:    op = SRAV;
                    `F_JR:      op = JR;
                    `F_JALR:    op = JALR;
                    `F_MULT:    op = MULT;
                    `F_MULTU:   op = MULTU;
                    `F_DIV:     op = DIV;
                    `F_DIVU:    op = DIVU;
                    `F_MFHI:    op = MFHI;
                    `F_MFLO:    op = MFLO;
                    `F_MTHI:    op = MTHI;
                    `F_MTLO:    op = MTLO;
                    `F_BREAK:   op = BREAK;
                    `F_SYSCALL: op = SYSCALL;
                    default:    op = RESERVED;
                endcase
            end
            default: op = RESERVED;
        endcase
    end

    assign exception_ri = (op == RESERVED);

    always_comb begin
        ctl = '0;
        case (op)
            ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR, LUI,
            SLL, SRL, SRA, SLLV, SRLV, SRAV: begin
                ctl.regwrite = 1'b1;
                if (imm_form) begin
                    ctl.alusrc  = IMM;
                    ctl.regdst  = RT;
                    ctl.zeroext = (op == AND) || (op == OR) || (op == XOR);
                end
                ctl.shamt_valid = (op == SLL) || (op == SRL) || (op == SRA);
            end
            BEQ, BNE: begin
                ctl.branch  = 1'b1;
                ctl.branch2 = 1'b1;
            end
            BGEZ, BLTZ, BGEZAL, BLTZAL, BGTZ, BLEZ: begin
                ctl.branch   = 1'b1;
                ctl.branch1  = 1'b1;
                ctl.regwrite = (op == BGEZAL) || (op == BLTZAL);  // link forms.
            end
            J, JAL: begin
                ctl.jump     = 1'b1;
                ctl.regwrite = (op == JAL);
            end
            JR, JALR: begin
                ctl.jump     = 1'b1;
                ctl.jr       = 1'b1;
                ctl.regwrite = (op == JALR);
            end
            LB, LBU, LH, LHU, LW: begin
                ctl.regwrite = 1'b1;
                ctl.memread  = 1'b1;
                ctl.regdst   = RT;
                ctl.alusrc   = IMM;
            end
            SB, SH, SW: begin
                ctl.memwrite = 1'b1;
                ctl.alusrc   = IMM;
            end
            MULT, MULTU, DIV, DIVU: begin
                ctl.hiwrite = 1'b1;
                ctl.lowrite = 1'b1;
            end
            MFHI, MFLO: ctl.regwrite = 1'b1;
            MTHI:       ctl.hiwrite = 1'b1;
            MTLO:       ctl.lowrite = 1'b1;
            MFC0: begin
                ctl.regwrite = 1'b1;
                ctl.regdst   = RT;
            end
            MTC0:    ctl.cp0write = 1'b1;
            ERET:    ctl.is_eret = 1'b1;
            BREAK:   ctl.is_bp = 1'b1;
            SYSCALL: ctl.is_sys = 1'b1;
            default: ;  // reserved leaves all flags clear.
        endcase

        case (op)
            BNE:            ctl.branch_type = T_BNE;
            BGEZ, BGEZAL:   ctl.branch_type = T_BGEZ;
            BLTZ, BLTZAL:   ctl.branch_type = T_BLTZ;
            BGTZ:           ctl.branch_type = T_BGTZ;
            BLEZ:           ctl.branch_type = T_BLEZ;
            default:        ctl.branch_type = T_BEQ;
        endcase

        case (op)
            ADDU:             ctl.alufunc = ALU_ADDU;
            SUB:              ctl.alufunc = ALU_SUB;
            SUBU:             ctl.alufunc = ALU_SUBU;
            SLT:              ctl.alufunc = ALU_SLT;
            SLTU:             ctl.alufunc = ALU_SLTU;
            AND:              ctl.alufunc = ALU_AND;
            OR:               ctl.alufunc = ALU_OR;
            XOR:              ctl.alufunc = ALU_XOR;
            NOR:              ctl.alufunc = ALU_NOR;
            LUI:              ctl.alufunc = ALU_LUI;
            SLL, SLLV:        ctl.alufunc = ALU_SLL;
            SRL, SRLV:        ctl.alufunc = ALU_SRL;
            SRA, SRAV:        ctl.alufunc = ALU_SRA;
            JR, JALR, MFHI, MFLO, MTHI, MTLO, BREAK, SYSCALL,
            RESERVED:         ctl.alufunc = ALU_PASSA;
            default:          ctl.alufunc = ALU_ADD;  // add, also for addresses.
        endcase
    end

endmodule

`default_nettype wire

/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  op_t;
    typedef logic [5:0]  func_t;

    // immediate and register forms share one entry.
    typedef enum logic [5:0] {
        ADD, ADDU, SUB, SUBU, SLT, SLTU,
        AND, OR, XOR, NOR, LUI,
        SLL, SRL, SRA, SLLV, SRLV, SRAV,
        BEQ, BNE, BGEZ, BLTZ, BGEZAL, BLTZAL, BGTZ, BLEZ,
        J, JAL, JR, JALR,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        MULT, MULTU, DIV, DIVU,
        MFHI, MFLO, MTHI, MTLO,
        ERET, MFC0, MTC0,
        BREAK, SYSCALL,
        RESERVED
    } decoded_op_t;

    // zero is add, used for address generation.
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_PASSA
    } alufunc_t;

    typedef enum logic [2:0] {
        T_BEQ, T_BNE, T_BGEZ, T_BLTZ, T_BGTZ, T_BLEZ
    } branch_type_t;

    typedef enum logic {RD = 1'b0, RT = 1'b1} regdst_t;

    typedef enum logic {REGB = 1'b0, IMM = 1'b1} alusrc_t;

    typedef struct packed {
        alufunc_t     alufunc;
        alusrc_t      alusrc;
        regdst_t      regdst;
        branch_type_t branch_type;
        logic         regwrite;
        logic         memread;
        logic         memwrite;
        logic         zeroext;
        logic         branch;
        logic         branch1;      // compares rs against zero.
        logic         branch2;      // compares rs against rt.
        logic         jump;
        logic         jr;
        logic         hiwrite;
        logic         lowrite;
        logic         shamt_valid;
        logic         cp0write;
        logic         is_eret;
        logic         is_bp;
        logic         is_sys;
    } control_t;

endpackage

`default_nettype wire

/* src/mips.svh */
`ifndef MIPS_SVH
`define MIPS_SVH

// primary opcodes, instr[31:26].
`define OP_RT       6'b000000
`define OP_BGEZ     6'b000001  // regimm group, rt selects.
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_ERET     6'b010000  // cop0 group, rs selects.
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011

// function codes for OP_RT, instr[5:0].
`define F_SLL       6'b000000
`define F_SRL       6'b000010
`define F_SRA       6'b000011
`define F_SLLV      6'b000100
`define F_SRLV      6'b000110
`define F_SRAV      6'b000111
`define F_JR        6'b001000
`define F_JALR      6'b001001
`define F_SYSCALL   6'b001100
`define F_BREAK     6'b001101
`define F_MFHI      6'b010000
`define F_MTHI      6'b010001
`define F_MFLO      6'b010010
`define F_MTLO      6'b010011
`define F_MULT      6'b011000
`define F_MULTU     6'b011001
`define F_DIV       6'b011010
`define F_DIVU      6'b011011
`define F_ADD       6'b100000
`define F_ADDU      6'b100001
`define F_SUB       6'b100010
`define F_SUBU      6'b100011
`define F_AND       6'b100100
`define F_OR        6'b100101
`define F_XOR       6'b100110
`define F_NOR       6'b100111
`define F_SLT       6'b101010
`define F_SLTU      6'b101011

// regimm rt field, instr[20:16].
`define B_BLTZ      5'b00000
`define B_BGEZ      5'b00001
`define B_BLTZAL    5'b10000
`define B_BGEZAL    5'b10001

// cop0 rs field, instr[25:21].
`define C_MFC0      5'b00000
`define C_MTC0      5'b00100
`define C_ERET      5'b10000

`endif
